//--- Makefile
TOP = div_pipe_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f div_pipe.f -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- div_pipe.f
hdl/div_pkg.sv
hdl/div_stage_if.sv
hdl/div_sign_prep.sv
hdl/div_step.sv
hdl/div_result.sv
hdl/div_pipe_top.sv
verification/div_pipe_props.sv
verification/div_pipe_checker.sv
verification/div_pipe_tb.sv

//--- hdl/div_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module div_pipe_top
	import div_pkg::*;
(
	input  wire           clk,
	input  wire           rst_n,
	input  wire           start,
	input  wire operand_t dividend,
	input  wire operand_t divisor,
	output logic          data_valid,
	output operand_t      quotient,
	output logic          div_by_zero
);

	// Boundary 0 follows the input stage, boundary DIV_STAGES feeds the output stage.
	div_stage_if stage_if [DIV_STAGES+1] ();

	div_sign_prep u_sign_prep (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.dividend (dividend),
		.divisor  (divisor),
		.out      (stage_if[0])
	);

	// The first step decides the most significant quotient bit.
	for (genvar i = 0; i < DIV_STAGES; i++) begin : g_step
		div_step u_step (
			.clk   (clk),
			.rst_n (rst_n),
			.up    (stage_if[i]),
			.down  (stage_if[i+1])
		);
	end

	div_result u_result (
		.clk         (clk),
		.rst_n       (rst_n),
		.up          (stage_if[DIV_STAGES]),
		.data_valid  (data_valid),
		.quotient    (quotient),
		.div_by_zero (div_by_zero)
	);

endmodule

`default_nettype wire

//--- hdl/div_pkg.sv
`default_nettype none

package div_pkg;

	// Operand, quotient and magnitude width in bits.
	localparam int OPERAND_W = 10;

	// The working register holds a remainder field and a dividend/quotient field.
	localparam int WORK_W = 2 * OPERAND_W;

	// One restoring step per quotient bit.
	localparam int DIV_STAGES = OPERAND_W;

	// Input stage, the division stages and the output stage.
	localparam int LATENCY = DIV_STAGES + 2;

	// Signed operand as seen on the ports.
	typedef logic signed [OPERAND_W-1:0] operand_t;

	// Unsigned magnitude. Wide enough for 512, the magnitude of the most negative operand.
	typedef logic [OPERAND_W-1:0] mag_t;

	// Upper half is the partial remainder, lower half shifts in quotient bits.
	typedef logic [WORK_W-1:0] work_t;

endpackage

`default_nettype wire

//--- hdl/div_result.sv
`timescale 1ns/1ps
`default_nettype none

module div_result
	import div_pkg::*;
(
	input  wire       clk,
	input  wire       rst_n,
	div_stage_if.sink up,
	output logic      data_valid,
	output operand_t  quotient,
	output logic      div_by_zero
);

	mag_t     quo_mag;
	operand_t quo_signed;

	// After the last step the lower field holds every quotient bit.
	always_comb begin
		quo_mag = up.work[OPERAND_W-1:0];

		if (up.dbz) begin
			quo_signed = '0;
		end else if (up.neg) begin
			quo_signed = operand_t'(-quo_mag); // Wraps modulo 2^10.
		end else begin
			quo_signed = operand_t'(quo_mag);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_valid  <= 1'b0;
			quotient    <= '0;
			div_by_zero <= 1'b0;
		end else begin
			data_valid <= up.valid;

			// Hold the last result between operations.
			if (up.valid) begin
				quotient    <= quo_signed;
				div_by_zero <= up.dbz;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/div_sign_prep.sv
`timescale 1ns/1ps
`default_nettype none

module div_sign_prep
	import div_pkg::*;
(
	input  wire           clk,
	input  wire           rst_n,
	input  wire           start,
	input  wire operand_t dividend,
	input  wire operand_t divisor,
	div_stage_if.source   out
);

	mag_t dividend_mag;
	mag_t divisor_mag;
	logic result_neg;
	logic divisor_zero;

	// Negation of -512 wraps to 10'h200, which reads as 512 unsigned.
	always_comb begin
		if (dividend[OPERAND_W-1]) begin
			dividend_mag = mag_t'(-dividend);
		end else begin
			dividend_mag = mag_t'(dividend);
		end

		if (divisor[OPERAND_W-1]) begin
			divisor_mag = mag_t'(-divisor);
		end else begin
			divisor_mag = mag_t'(divisor);
		end

		result_neg   = dividend[OPERAND_W-1] ^ divisor[OPERAND_W-1]; // Signs differ.
		divisor_zero = (divisor == '0);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out.valid <= 1'b0;
			out.neg   <= 1'b0;
			out.dbz   <= 1'b0;
			out.dvsr  <= '0;
			out.work  <= '0;
		end else begin
			out.valid <= start;
			out.neg   <= result_neg;
			out.dbz   <= divisor_zero;
			out.dvsr  <= divisor_mag;
			out.work  <= {mag_t'(0), dividend_mag}; // Remainder starts empty.
		end
	end

endmodule

`default_nettype wire

//--- hdl/div_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

interface div_stage_if
	import div_pkg::*;
();

	logic  valid; // An operation occupies this stage boundary.
	logic  neg;   // The quotient must be negated at the end.
	logic  dbz;   // The divisor was zero.
	work_t work;  // Partial remainder and quotient bits.
	mag_t  dvsr;  // Divisor magnitude.

	// Driven by the stage on the upstream side of the boundary.
	modport source (
		output valid,
		output neg,
		output dbz,
		output work,
		output dvsr
	);

	// Read by the stage on the downstream side of the boundary.
	modport sink (
		input valid,
		input neg,
		input dbz,
		input work,
		input dvsr
	);

endinterface

`default_nettype wire

//--- hdl/div_step.sv
`timescale 1ns/1ps
`default_nettype none

module div_step
	import div_pkg::*;
(
	input  wire         clk,
	input  wire         rst_n,
	div_stage_if.sink   up,
	div_stage_if.source down
);

	work_t shifted;
	mag_t  rem_shifted;
	mag_t  rem_next;
	logic  fits;
	work_t work_next;

	// The remainder stays below the divisor, so the bit shifted out is always zero.
	always_comb begin
		shifted     = up.work << 1;
		rem_shifted = shifted[WORK_W-1:OPERAND_W];
		fits        = (rem_shifted >= up.dvsr); // Divisor goes into the remainder.
		rem_next    = rem_shifted - up.dvsr;

		if (fits) begin
			work_next = {rem_next, shifted[OPERAND_W-1:1], 1'b1};
		end else begin
			work_next = shifted;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			down.valid <= 1'b0;
			down.neg   <= 1'b0;
			down.dbz   <= 1'b0;
			down.dvsr  <= '0;
			down.work  <= '0;
		end else begin
			down.valid <= up.valid;
			down.neg   <= up.neg;
			down.dbz   <= up.dbz;
			down.dvsr  <= up.dvsr;
			down.work  <= work_next;
		end
	end

endmodule

`default_nettype wire

//--- verification/div_pipe_checker.sv
`timescale 1ns/1ps
`default_nettype none

module div_pipe_checker
	import div_pkg::*;
(
	input wire           clk,
	input wire           rst_n,
	input wire           start,
	input wire           data_valid,
	input wire operand_t quotient,
	input wire           div_by_zero
);

	operand_t exp_quotient[$];
	logic     exp_dbz[$];
	int       start_cycle[$]; // Edge number at which each start was sampled.
	int       cycle = 0;
	int       done_count = 0;
	int       pass_count = 0;
	int       fail_count = 0;
	logic     seen_result = 1'b0;

	task automatic expect_result(input operand_t q, input logic dbz);
		exp_quotient.push_back(q);
		exp_dbz.push_back(dbz);
	endtask

	always @(posedge clk) begin
		operand_t q_exp;
		logic     dbz_exp;
		int       issued_at;
		logic     ok;

		cycle++;
		if (!rst_n) begin
			if (data_valid || div_by_zero) begin
				$display("Error at %0t: outputs are not cleared during reset", $time);
				fail_count++;
			end
		end else begin
			if (start) begin
				start_cycle.push_back(cycle);
			end
			if (!seen_result && !data_valid && div_by_zero) begin
				$display("Error at %0t: div_by_zero set before the first result", $time);
				fail_count++;
			end
			if (data_valid && (exp_quotient.size() == 0 || start_cycle.size() == 0)) begin
				$display("Error at %0t: a result arrived with no operation pending", $time);
				fail_count++;
			end else if (data_valid) begin
				seen_result = 1'b1;
				ok          = 1'b1;
				q_exp       = exp_quotient.pop_front();
				dbz_exp     = exp_dbz.pop_front();
				issued_at   = start_cycle.pop_front();
				if (quotient !== q_exp) begin
					$display("Mismatch at %0t: quotient expected %0d, actual %0d",
						$time, q_exp, quotient);
					ok = 1'b0;
				end
				if (div_by_zero !== dbz_exp) begin
					$display("Mismatch at %0t: div_by_zero expected %0b, actual %0b",
						$time, dbz_exp, div_by_zero);
					ok = 1'b0;
				end
				if (cycle - issued_at != LATENCY) begin
					$display("Error at %0t: result came %0d cycles after its start, not %0d",
						$time, cycle - issued_at, LATENCY);
					ok = 1'b0;
				end
				done_count++;
				if (ok) begin
					pass_count++;
				end else begin
					fail_count++;
				end
				$display("Test %0d %s: quotient %0d, div_by_zero %0b", done_count,
					ok ? "passed" : "failed", quotient, div_by_zero);
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/div_pipe_props.sv
`timescale 1ns/1ps
`default_nettype none

module div_pipe_props
	import div_pkg::*;
(
	input wire           clk,
	input wire           rst_n,
	input wire           start,
	input wire           data_valid,
	input wire operand_t quotient,
	input wire           div_by_zero
);

	int fail_count = 0; // Read by the testbench at the end of the run.

	// Every accepted operation leaves the pipe a fixed number of edges later.
	a_latency: assert property (@(posedge clk) disable iff (!rst_n) start |-> ##LATENCY data_valid)
		else begin
			$error("data_valid did not follow start after %0d cycles", LATENCY);
			fail_count++;
		end

	a_dbz_zero: assert property (@(posedge clk) disable iff (!rst_n)
		data_valid && div_by_zero |-> quotient == '0)
		else begin
			$error("Nonzero quotient reported together with div_by_zero");
			fail_count++;
		end

	a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !data_valid)
		else begin
			$error("data_valid high while reset is asserted");
			fail_count++;
		end

endmodule

bind div_pipe_top div_pipe_props u_props (
	.clk         (clk),
	.rst_n       (rst_n),
	.start       (start),
	.data_valid  (data_valid),
	.quotient    (quotient),
	.div_by_zero (div_by_zero)
);

`default_nettype wire

//--- verification/div_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module div_pipe_tb
	import div_pkg::*;
();

	localparam int NUM_VEC    = 17;
	localparam int NUM_RAND   = 200;
	localparam int WAIT_LIMIT = 4 * LATENCY;

	logic        clk;
	logic        rst_n;
	logic        start;
	operand_t    dividend;
	operand_t    divisor;
	logic        data_valid;
	operand_t    quotient;
	logic        div_by_zero;
	int unsigned lcg_state;
	logic        timed_out;
	int          issued;

	// One column per field. Row i is dividend, divisor, quotient and div_by_zero of entry i.
	int tbl_dividend [NUM_VEC] = '{100, 3, 45, -7, 7, -7, -100, 25, -25, 0,
		-512, 511, -512, 0, -1, 511, -512};
	int tbl_divisor  [NUM_VEC] = '{7, 9, 5, 2, -2, -2, -7, 0, 0, 0,
		-1, 1, 2, 5, 3, -512, 511};
	int tbl_quotient [NUM_VEC] = '{14, 0, 9, -3, -3, 3, 14, 0, 0, 0,
		-512, 511, -256, 0, 0, 0, -1};
	bit tbl_dbz      [NUM_VEC] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1,
		1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};

	initial clk = 1'b0;
	always #50 clk = ~clk;

	div_pipe_top UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.dividend    (dividend),
		.divisor     (divisor),
		.data_valid  (data_valid),
		.quotient    (quotient),
		.div_by_zero (div_by_zero)
	);

	div_pipe_checker u_checker (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.data_valid  (data_valid),
		.quotient    (quotient),
		.div_by_zero (div_by_zero)
	);

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic operand_t expected_quotient(input operand_t a, input operand_t b);
		int num;
		int den;
		num = int'(a);
		den = int'(b);
		if (den == 0) begin
			return '0;
		end
		return operand_t'(num / den); // Integer division truncates toward zero, the cast wraps.
	endfunction

	task automatic issue_op(input operand_t a, input operand_t b, input operand_t q,
		input logic dbz);
		@(posedge clk);
		#1;
		start    = 1'b1;
		dividend = a;
		divisor  = b;
		u_checker.expect_result(q, dbz);
		issued++;
	endtask

	task automatic go_idle();
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	task automatic wait_results(input int total);
		int waited;
		waited = 0;
		while (u_checker.done_count < total && waited < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (u_checker.done_count < total) begin
			$display("Timeout: only %0d of %0d results arrived", u_checker.done_count, total);
			timed_out = 1'b1;
		end
	endtask

	initial begin
		operand_t a;
		operand_t b;
		rst_n     = 1'b0;
		start     = 1'b0;
		dividend  = '0;
		divisor   = '0;
		timed_out = 1'b0;
		issued    = 0;
		lcg_state = 55328;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (2) @(posedge clk);
		for (int i = 0; i < NUM_VEC; i++) begin
			issue_op(operand_t'(tbl_dividend[i]), operand_t'(tbl_divisor[i]),
				operand_t'(tbl_quotient[i]), tbl_dbz[i]);
		end
		go_idle();
		wait_results(issued);
		for (int i = 0; i < NUM_RAND; i++) begin
			lcg_state = lcg_next(lcg_state);
			a         = operand_t'(lcg_state[25:16]);
			lcg_state = lcg_next(lcg_state);
			if (lcg_state[31]) begin
				b = operand_t'($signed(lcg_state[20:16])); // Small divisors spread the quotients.
			end else begin
				b = operand_t'(lcg_state[25:16]);
			end
			issue_op(a, b, expected_quotient(a, b), b == '0);
		end
		go_idle();
		wait_results(issued);
		$display("Summary: %0d passed, %0d failed, %0d assertion failures",
			u_checker.pass_count, u_checker.fail_count, UUT.u_props.fail_count);
		if (!timed_out && u_checker.fail_count == 0 && UUT.u_props.fail_count == 0
			&& u_checker.pass_count == issued) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
